/* rv_pkg.sv */
package rv_pkg;

  parameter int XLEN      = 32;
  parameter int REG_ADDRW = 5;
  parameter int CSR_ADDRW = 12;

  // major opcodes.
  parameter logic [6:0] OP_OP    = 7'b0110011;
  parameter logic [6:0] OP_IMM   = 7'b0010011;
  parameter logic [6:0] OP_LUI   = 7'b0110111;
  parameter logic [6:0] OP_AUIPC = 7'b0010111;
  parameter logic [6:0] OP_SYS   = 7'b1110011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_NOP
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_RS1,
    SRC_PC,
    SRC_ZERO
  } src_sel_e;  // first alu operand.

  typedef enum logic [1:0] {
    CSR_NOP,
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_e;

  parameter logic [CSR_ADDRW-1:0] CSR_MSCRATCH = 12'h340;
  parameter logic [CSR_ADDRW-1:0] CSR_MTVEC    = 12'h305;
  parameter logic [CSR_ADDRW-1:0] CSR_MEPC     = 12'h341;
  parameter logic [CSR_ADDRW-1:0] CSR_MCAUSE   = 12'h342;

  parameter logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;  // ecall from m-mode.

endpackage

/* dec_if.sv */
`timescale 1ns/1ps
interface dec_if;

  logic                          valid;
  logic                          ready;
  logic [rv_pkg::XLEN-1:0]       pc;
  logic [rv_pkg::REG_ADDRW-1:0]  rs1id;  // also carries zimm.
  logic [rv_pkg::REG_ADDRW-1:0]  rs2id;
  logic [rv_pkg::REG_ADDRW-1:0]  rdid;
  logic                          rdwen;
  logic [rv_pkg::XLEN-1:0]       imm;
  rv_pkg::src_sel_e              src_sel;
  logic                          use_imm;
  rv_pkg::alu_op_e               alu_op;
  rv_pkg::csr_op_e               csr_op;
  logic [rv_pkg::CSR_ADDRW-1:0]  csr_addr;
  logic                          csr_use_imm;
  logic                          ecall;
  logic                          mret;
  logic [rv_pkg::XLEN-1:0]       rs1_val;  // from register file.
  logic [rv_pkg::XLEN-1:0]       rs2_val;

  modport dec (
    output valid, pc, rs1id, rs2id, rdid, rdwen, imm, src_sel, use_imm, alu_op,
    output csr_op, csr_addr, csr_use_imm, ecall, mret,
    input  ready
  );

  modport exe (
    input  valid, pc, rs1id, rs2id, rdid, rdwen, imm, src_sel, use_imm, alu_op,
    input  csr_op, csr_addr, csr_use_imm, ecall, mret, rs1_val, rs2_val,
    output ready
  );

  modport rf (
    input  rs1id, rs2id,
    output rs1_val, rs2_val
  );

endinterface

/* res_if.sv */
`timescale 1ns/1ps
interface res_if;

  logic                         valid;
  logic                         ready;
  logic [rv_pkg::XLEN-1:0]      pc;
  logic                         rdwen;
  logic [rv_pkg::REG_ADDRW-1:0] rdid;
  logic [rv_pkg::XLEN-1:0]      data;
  logic                         trap;     // ecall or mret.
  logic [rv_pkg::XLEN-1:0]      trap_pc;

  modport src (
    output valid, pc, rdwen, rdid, data, trap, trap_pc,
    input  ready
  );

  modport dst (
    input  valid, pc, rdwen, rdid, data, trap, trap_pc,
    output ready
  );

endinterface

/* idu_normal.sv */
`timescale 1ns/1ps
module idu_normal (
  input  logic [rv_pkg::XLEN-1:0]      i_ins,
  output logic [rv_pkg::REG_ADDRW-1:0] o_rs1id,
  output logic [rv_pkg::REG_ADDRW-1:0] o_rs2id,
  output logic [rv_pkg::REG_ADDRW-1:0] o_rdid,
  output logic                         o_rdwen,
  output logic [rv_pkg::XLEN-1:0]      o_imm,
  output rv_pkg::src_sel_e             o_src_sel,
  output logic                         o_use_imm,
  output rv_pkg::alu_op_e              o_alu_op
);

  logic [6:0] opcode;
  logic [2:0] func3;

  // funct3 to alu op, alt picks sub/sra.
  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode  = i_ins[6:0];
  assign func3   = i_ins[14:12];
  assign o_rs1id = i_ins[19:15];
  assign o_rs2id = i_ins[24:20];
  assign o_rdid  = i_ins[11:7];

  always_comb begin
    o_rdwen   = 1'b0;
    o_imm     = '0;
    o_src_sel = rv_pkg::SRC_RS1;
    o_use_imm = 1'b0;
    o_alu_op  = rv_pkg::ALU_NOP;  // unknown opcodes retire as no-op.
    case (opcode)
      rv_pkg::OP_OP: begin
        o_rdwen  = 1'b1;
        o_alu_op = alu_sel(func3, i_ins[30]);
      end
      rv_pkg::OP_IMM: begin
        o_rdwen   = 1'b1;
        o_use_imm = 1'b1;
        o_imm     = {{20{i_ins[31]}}, i_ins[31:20]};
        o_alu_op  = alu_sel(func3, i_ins[30] & (func3 == 3'b101));  // no subi.
      end
      rv_pkg::OP_LUI, rv_pkg::OP_AUIPC: begin
        o_rdwen   = 1'b1;
        o_use_imm = 1'b1;
        o_imm     = {i_ins[31:12], 12'b0};
        o_src_sel = (opcode == rv_pkg::OP_LUI) ? rv_pkg::SRC_ZERO : rv_pkg::SRC_PC;
        o_alu_op  = rv_pkg::ALU_ADD;
      end
      default: ;
    endcase
  end

endmodule

/* idu_system.sv */
`timescale 1ns/1ps
module idu_system (
  input  logic [rv_pkg::XLEN-1:7]      i_ins_hi,
  output logic [rv_pkg::REG_ADDRW-1:0] o_rs1id,
  output logic [rv_pkg::REG_ADDRW-1:0] o_rdid,
  output logic                         o_rdwen,
  output logic [rv_pkg::CSR_ADDRW-1:0] o_csr_addr,
  output rv_pkg::csr_op_e              o_csr_op,
  output logic                         o_csr_use_imm
);

  logic [2:0] func3;

  assign func3         = i_ins_hi[14:12];
  assign o_rs1id       = i_ins_hi[19:15];  // rs1 or zimm.
  assign o_rdid        = i_ins_hi[11:7];
  assign o_csr_addr    = i_ins_hi[31:20];
  assign o_csr_use_imm = func3[2];         // csrr*i forms.

  always_comb begin
    case (func3[1:0])
      2'b01:   o_csr_op = rv_pkg::CSR_RW;
      2'b10:   o_csr_op = rv_pkg::CSR_RS;
      2'b11:   o_csr_op = rv_pkg::CSR_RC;
      default: o_csr_op = rv_pkg::CSR_NOP;  // ecall, mret and others.
    endcase
  end

  assign o_rdwen = (o_csr_op != rv_pkg::CSR_NOP);

endmodule

/* idu.sv */
`timescale 1ns/1ps
module idu (
  input  logic [rv_pkg::XLEN-1:0] i_ins,
  input  logic [rv_pkg::XLEN-1:0] i_pc,
  input  logic                    i_valid,
  output logic                    o_ready,
  dec_if.dec                      dec
);

  logic                         sysins;
  logic [rv_pkg::REG_ADDRW-1:0] nom_rs1id;
  logic [rv_pkg::REG_ADDRW-1:0] nom_rs2id;
  logic [rv_pkg::REG_ADDRW-1:0] nom_rdid;
  logic                         nom_rdwen, sys_rdwen;
  logic [rv_pkg::XLEN-1:0]      nom_imm;
  rv_pkg::src_sel_e             nom_src_sel;
  logic                         nom_use_imm;
  rv_pkg::alu_op_e              nom_alu_op;
  logic [rv_pkg::CSR_ADDRW-1:0] sys_csr_addr;
  rv_pkg::csr_op_e              sys_csr_op;
  logic                         sys_csr_use_imm;

  assign sysins = (i_ins[6:0] == rv_pkg::OP_SYS);

  idu_normal u_idu_normal (
    .i_ins    (i_ins),
    .o_rs1id  (nom_rs1id),
    .o_rs2id  (nom_rs2id),
    .o_rdid   (nom_rdid),
    .o_rdwen  (nom_rdwen),
    .o_imm    (nom_imm),
    .o_src_sel(nom_src_sel),
    .o_use_imm(nom_use_imm),
    .o_alu_op (nom_alu_op)
  );

  idu_system u_idu_system (
    .i_ins_hi     (i_ins[rv_pkg::XLEN-1:7]),
    .o_rs1id      (),
    .o_rdid       (),
    .o_rdwen      (sys_rdwen),
    .o_csr_addr   (sys_csr_addr),
    .o_csr_op     (sys_csr_op),
    .o_csr_use_imm(sys_csr_use_imm)
  );

  assign dec.pc          = i_pc;
  assign dec.rs1id       = nom_rs1id;  // same field in every format.
  assign dec.rs2id       = sysins ? '0 : nom_rs2id;
  assign dec.rdid        = nom_rdid;
  assign dec.rdwen       = sysins ? sys_rdwen : nom_rdwen;
  assign dec.imm         = sysins ? '0 : nom_imm;
  assign dec.src_sel     = sysins ? rv_pkg::SRC_ZERO : nom_src_sel;
  assign dec.use_imm     = sysins ? 1'b0 : nom_use_imm;
  assign dec.alu_op      = sysins ? rv_pkg::ALU_NOP : nom_alu_op;  // csr result bypasses alu.
  assign dec.csr_op      = sysins ? sys_csr_op : rv_pkg::CSR_NOP;
  assign dec.csr_addr    = sysins ? sys_csr_addr : '0;
  assign dec.csr_use_imm = sysins ? sys_csr_use_imm : 1'b0;

  // exact encodings, everything above the opcode fixed.
  assign dec.ecall = sysins & (i_ins[31:7] == 25'b0);
  assign dec.mret  = sysins & (i_ins[31:7] == {12'h302, 13'b0});

  assign o_ready   = dec.ready;
  assign dec.valid = i_valid;

  // trap flags are exclusive and never write a register.
  always_comb begin
    if (i_valid) begin
      assert (!(dec.ecall && dec.mret) && !((dec.ecall || dec.mret) && dec.rdwen))
        else $error("idu: bad trap decode");
    end
  end

endmodule

/* exu.sv */
`timescale 1ns/1ps
module exu #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_MTVEC = '0
) (
  input logic i_clk,
  input logic i_rst,
  dec_if.exe  dec,
  res_if.src  res
);

  logic                         accept;
  logic [rv_pkg::XLEN-1:0]      rs1, rs2, op_a, op_b, alu_res;
  logic [rv_pkg::XLEN-1:0]      csr_old, csr_src, csr_new;
  logic [rv_pkg::XLEN-1:0]      mscratch, mtvec, mepc, mcause;
  logic                         s_valid, s_rdwen, s_trap;
  logic [rv_pkg::REG_ADDRW-1:0] s_rdid;
  logic [rv_pkg::XLEN-1:0]      s_pc, s_data, s_trap_pc;

  assign dec.ready = !s_valid || res.ready;  // one slot, drains while refilled.
  assign accept    = dec.valid && dec.ready;

  // forward from the stage when it still holds the producer.
  assign rs1 = (s_valid && s_rdwen && dec.rs1id != '0 && s_rdid == dec.rs1id) ?
               s_data : dec.rs1_val;
  assign rs2 = (s_valid && s_rdwen && dec.rs2id != '0 && s_rdid == dec.rs2id) ?
               s_data : dec.rs2_val;

  always_comb begin
    case (dec.src_sel)
      rv_pkg::SRC_RS1: op_a = rs1;
      rv_pkg::SRC_PC:  op_a = dec.pc;
      default:         op_a = '0;
    endcase
  end
  assign op_b = dec.use_imm ? dec.imm : rs2;

  always_comb begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:  alu_res = op_a + op_b;
      rv_pkg::ALU_SUB:  alu_res = op_a - op_b;
      rv_pkg::ALU_SLL:  alu_res = op_a << op_b[4:0];
      rv_pkg::ALU_SLT:  alu_res = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU: alu_res = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
      rv_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      rv_pkg::ALU_SRL:  alu_res = op_a >> op_b[4:0];
      rv_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      rv_pkg::ALU_OR:   alu_res = op_a | op_b;
      rv_pkg::ALU_AND:  alu_res = op_a & op_b;
      default:          alu_res = '0;
    endcase
  end

  always_comb begin
    case (dec.csr_addr)
      rv_pkg::CSR_MSCRATCH: csr_old = mscratch;
      rv_pkg::CSR_MTVEC:    csr_old = mtvec;
      rv_pkg::CSR_MEPC:     csr_old = mepc;
      rv_pkg::CSR_MCAUSE:   csr_old = mcause;
      default:              csr_old = '0;  // unlisted csr.
    endcase
  end

  assign csr_src = dec.csr_use_imm ?
                   {{(rv_pkg::XLEN-rv_pkg::REG_ADDRW){1'b0}}, dec.rs1id} : rs1;

  always_comb begin
    case (dec.csr_op)
      rv_pkg::CSR_RS: csr_new = csr_old | csr_src;
      rv_pkg::CSR_RC: csr_new = csr_old & ~csr_src;
      default:        csr_new = csr_src;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mscratch <= '0;
      mtvec    <= RESET_MTVEC;
      mepc     <= '0;
      mcause   <= '0;
    end else if (accept) begin
      if (dec.ecall) begin
        mepc   <= dec.pc;
        mcause <= rv_pkg::CAUSE_ECALL_M;
      end else if (dec.csr_op != rv_pkg::CSR_NOP) begin
        case (dec.csr_addr)
          rv_pkg::CSR_MSCRATCH: mscratch <= csr_new;
          rv_pkg::CSR_MTVEC:    mtvec    <= csr_new;
          rv_pkg::CSR_MEPC:     mepc     <= csr_new;
          rv_pkg::CSR_MCAUSE:   mcause   <= csr_new;
          default: ;  // write dropped.
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s_valid <= 1'b0;
    end else if (accept) begin
      s_valid <= 1'b1;
    end else if (res.ready) begin
      s_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      s_pc      <= dec.pc;
      s_rdwen   <= dec.rdwen;
      s_rdid    <= dec.rdid;
      s_data    <= (dec.csr_op != rv_pkg::CSR_NOP) ? csr_old : alu_res;
      s_trap    <= dec.ecall || dec.mret;
      s_trap_pc <= dec.ecall ? mtvec : (dec.mret ? mepc : '0);
    end
  end

  assign res.valid   = s_valid;
  assign res.pc      = s_pc;
  assign res.rdwen   = s_rdwen;
  assign res.rdid    = s_rdid;
  assign res.data    = s_data;
  assign res.trap    = s_trap;
  assign res.trap_pc = s_trap_pc;

  a_stage_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    s_valid && !res.ready |=>
      s_valid && $stable({s_pc, s_rdwen, s_rdid, s_data, s_trap, s_trap_pc}))
    else $error("exu: stage changed under back-pressure");

endmodule

/* wbu.sv */
`timescale 1ns/1ps
module wbu (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic                         i_wb_ready,
  output logic                         o_wb_valid,
  output logic [rv_pkg::XLEN-1:0]      o_wb_pc,
  output logic                         o_wb_rdwen,
  output logic [rv_pkg::REG_ADDRW-1:0] o_wb_rdid,
  output logic [rv_pkg::XLEN-1:0]      o_wb_data,
  output logic                         o_wb_trap,
  output logic [rv_pkg::XLEN-1:0]      o_wb_trap_pc,
  res_if.dst                           res,
  dec_if.rf                            rf
);

  logic [rv_pkg::XLEN-1:0] regs [1:31];  // x0 not stored.
  logic                    wen;

  assign res.ready = i_wb_ready;
  assign wen       = res.valid && res.ready && res.rdwen && (res.rdid != '0);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[res.rdid] <= res.data;
    end
  end

  // same-edge write is visible to the reader.
  assign rf.rs1_val = (rf.rs1id == '0) ? '0 :
                      (wen && res.rdid == rf.rs1id) ? res.data : regs[rf.rs1id];
  assign rf.rs2_val = (rf.rs2id == '0) ? '0 :
                      (wen && res.rdid == rf.rs2id) ? res.data : regs[rf.rs2id];

  assign o_wb_valid   = res.valid;
  assign o_wb_pc      = res.pc;
  assign o_wb_rdwen   = res.rdwen;
  assign o_wb_rdid    = res.rdid;
  assign o_wb_data    = res.data;
  assign o_wb_trap    = res.trap;
  assign o_wb_trap_pc = res.trap_pc;

  a_wb_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wb_valid && !i_wb_ready |=> o_wb_valid && $stable(o_wb_pc))
    else $error("wbu: retire record dropped without transfer");

endmodule

/* rv_core.sv */
`timescale 1ns/1ps
module rv_core #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_MTVEC = 32'h0000_0100
) (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic                         i_valid,
  input  logic [rv_pkg::XLEN-1:0]      i_pc,
  input  logic [rv_pkg::XLEN-1:0]      i_ins,
  input  logic                         i_wb_ready,
  output logic                         o_ready,
  output logic                         o_wb_valid,
  output logic [rv_pkg::XLEN-1:0]      o_wb_pc,
  output logic                         o_wb_rdwen,
  output logic [rv_pkg::REG_ADDRW-1:0] o_wb_rdid,
  output logic [rv_pkg::XLEN-1:0]      o_wb_data,
  output logic                         o_wb_trap,
  output logic [rv_pkg::XLEN-1:0]      o_wb_trap_pc
);

  dec_if u_dec ();
  res_if u_res ();

  idu u_idu (
    .i_ins  (i_ins),
    .i_pc   (i_pc),
    .i_valid(i_valid),
    .o_ready(o_ready),
    .dec    (u_dec.dec)
  );

  exu #(
    .RESET_MTVEC(RESET_MTVEC)
  ) u_exu (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .dec  (u_dec.exe),
    .res  (u_res.src)
  );

  wbu u_wbu (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_wb_ready  (i_wb_ready),
    .o_wb_valid  (o_wb_valid),
    .o_wb_pc     (o_wb_pc),
    .o_wb_rdwen  (o_wb_rdwen),
    .o_wb_rdid   (o_wb_rdid),
    .o_wb_data   (o_wb_data),
    .o_wb_trap   (o_wb_trap),
    .o_wb_trap_pc(o_wb_trap_pc),
    .res         (u_res.dst),
    .rf          (u_dec.rf)  // register reads back into decode.
  );

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ps
module tb_rv_core;

  localparam logic [31:0] MTVEC_INIT = 32'h0000_0200;
  localparam int          WAIT_LIMIT = 200;  // cycles per wait loop.
  localparam logic [31:0] INS_ECALL  = 32'h0000_0073;
  localparam logic [31:0] INS_MRET   = 32'h3020_0073;

  typedef struct packed {
    logic [31:0] pc;
    logic        rdwen;
    logic [4:0]  rdid;
    logic [31:0] data;
    logic        trap;
    logic [31:0] trap_pc;
  } retire_t;

  logic        i_clk, i_rst, i_valid, i_wb_ready;
  logic [31:0] i_pc, i_ins;
  logic        o_ready, o_wb_valid, o_wb_rdwen, o_wb_trap;
  logic [4:0]  o_wb_rdid;
  logic [31:0] o_wb_pc, o_wb_data, o_wb_trap_pc;

  logic [31:0] lcg_state = 32'h3ecb_ce39;
  logic [31:0] cur_pc;
  logic [31:0] ref_regs [32];
  logic [31:0] ref_mscratch, ref_mtvec, ref_mepc, ref_mcause;
  retire_t     exp_q [$];  // accepted, not yet retired.
  retire_t     head;
  int          errors, sent, retired, tests, err_mark, sent_mark;

  rv_core #(.RESET_MTVEC(MTVEC_INIT)) DUT (.*);

  always #5 i_clk = ~i_clk;

  function automatic logic [31:0] rnd();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};  // high bits first.
  endfunction

  function automatic logic [31:0] rv_alu(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    case (f3)
      3'b000:  res = alt ? a - b : a + b;
      3'b001:  res = a << b[4:0];
      3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  res = (a < b) ? 32'd1 : 32'd0;
      3'b100:  res = a ^ b;
      3'b101: begin
        if (alt) res = $signed(a) >>> b[4:0];
        else res = a >> b[4:0];
      end
      3'b110:  res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic [31:0] csr_read(input logic [11:0] addr);
    case (addr)
      rv_pkg::CSR_MSCRATCH: return ref_mscratch;
      rv_pkg::CSR_MTVEC:    return ref_mtvec;
      rv_pkg::CSR_MEPC:     return ref_mepc;
      rv_pkg::CSR_MCAUSE:   return ref_mcause;
      default:              return 32'd0;
    endcase
  endfunction

  // architectural model, applied in program order.
  function automatic retire_t ref_step(input logic [31:0] pc, input logic [31:0] ins);
    retire_t     r;
    logic [31:0] a, old, src, nv;
    r = '0;
    r.pc = pc;
    r.rdid = ins[11:7];
    a = ref_regs[ins[19:15]];
    case (ins[6:0])
      rv_pkg::OP_OP: begin
        r.rdwen = 1'b1;
        r.data = rv_alu(ins[14:12], ins[30], a, ref_regs[ins[24:20]]);
      end
      rv_pkg::OP_IMM: begin
        r.rdwen = 1'b1;
        r.data = rv_alu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a,
                        {{20{ins[31]}}, ins[31:20]});
      end
      rv_pkg::OP_LUI: begin
        r.rdwen = 1'b1;
        r.data = {ins[31:12], 12'b0};
      end
      rv_pkg::OP_AUIPC: begin
        r.rdwen = 1'b1;
        r.data = pc + {ins[31:12], 12'b0};
      end
      rv_pkg::OP_SYS: begin
        if (ins == INS_ECALL) begin
          r.trap = 1'b1;
          r.trap_pc = ref_mtvec;
          ref_mepc = pc;
          ref_mcause = rv_pkg::CAUSE_ECALL_M;
        end else if (ins == INS_MRET) begin
          r.trap = 1'b1;
          r.trap_pc = ref_mepc;
        end else if (ins[13:12] != 2'b00) begin
          old = csr_read(ins[31:20]);
          src = ins[14] ? {27'd0, ins[19:15]} : a;  // zimm or rs1.
          case (ins[13:12])
            2'b01:   nv = src;
            2'b10:   nv = old | src;
            default: nv = old & ~src;
          endcase
          case (ins[31:20])
            rv_pkg::CSR_MSCRATCH: ref_mscratch = nv;
            rv_pkg::CSR_MTVEC:    ref_mtvec = nv;
            rv_pkg::CSR_MEPC:     ref_mepc = nv;
            rv_pkg::CSR_MCAUSE:   ref_mcause = nv;
            default: ;
          endcase
          r.rdwen = 1'b1;
          r.data = old;
        end
      end
      default: ;  // unsupported, no write.
    endcase
    if (r.rdwen && r.rdid != 5'd0) ref_regs[r.rdid] = r.data;
    return r;
  endfunction

  function automatic logic [31:0] gen_alu();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [11:0] imm;
    r = rnd();
    f3 = r[2:0];
    imm = r[23:12];
    if (r[24]) begin
      return {1'b0, r[25] && (f3 == 3'b000 || f3 == 3'b101), 5'b0, 2'b00, r[11:9],
              2'b00, r[8:6], f3, 2'b00, r[5:3], rv_pkg::OP_OP};
    end
    if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, r[25] && f3 == 3'b101, 5'b0, imm[4:0]};
    return {imm, 2'b00, r[8:6], f3, 2'b00, r[5:3], rv_pkg::OP_IMM};
  endfunction

  function automatic logic [31:0] gen_upper();
    logic [31:0] r;
    r = rnd();
    return {r[31:12], 2'b00, r[7:5], r[0] ? rv_pkg::OP_LUI : rv_pkg::OP_AUIPC};
  endfunction

  function automatic logic [31:0] csr_ins(input logic [11:0] addr, input logic [4:0] src,
                                          input logic [2:0] f3, input logic [4:0] rd);
    return {addr, src, f3, rd, rv_pkg::OP_SYS};
  endfunction

  function automatic logic [31:0] gen_csr();
    logic [31:0] r;
    logic [11:0] addr;
    logic [2:0]  f3;
    r = rnd();
    case (r[2:0])
      3'd0, 3'd4: addr = rv_pkg::CSR_MSCRATCH;
      3'd1:       addr = rv_pkg::CSR_MTVEC;
      3'd2, 3'd5: addr = rv_pkg::CSR_MEPC;
      3'd3, 3'd6: addr = rv_pkg::CSR_MCAUSE;
      default:    addr = 12'h300;  // not implemented.
    endcase
    f3 = {r[5], (r[4:3] == 2'b00) ? 2'b01 : r[4:3]};
    return csr_ins(addr, f3[2] ? r[10:6] : {2'b00, r[8:6]}, f3, {2'b00, r[13:11]});
  endfunction

  function automatic logic [31:0] gen_unknown();
    logic [31:0] r;
    logic [6:0]  op;
    r = rnd();
    op = r[6:0];
    if (op == rv_pkg::OP_OP || op == rv_pkg::OP_IMM || op == rv_pkg::OP_LUI ||
        op == rv_pkg::OP_AUIPC || op == rv_pkg::OP_SYS) op = 7'b0000011;
    return {r[31:7], op};
  endfunction

  function automatic logic [31:0] gen_mixed();
    logic [3:0] sel;
    sel = rnd() % 16;
    if (sel < 8) return gen_alu();
    else if (sel < 10) return gen_upper();
    else if (sel < 13) return gen_csr();
    else if (sel == 13) return INS_ECALL;
    else if (sel == 14) return INS_MRET;
    else return gen_unknown();
  endfunction

  function automatic logic [31:0] read_reg(input logic [4:0] r);
    return {7'b0, 5'd0, r, 3'b000, r, rv_pkg::OP_OP};  // add r, r, x0.
  endfunction

  task automatic abort_run(input string why);
    $display("%s at %0t", why, $time);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge i_clk);
    #1;
    i_wb_ready = (rnd() & 32'h3) != 32'h0;  // ready about 3 of 4 cycles.
  endtask

  task automatic send_ins(input logic [31:0] ins);
    int   waited;
    logic done;
    waited = 0;
    done = 1'b0;
    i_valid = 1'b1;
    i_ins = ins;
    i_pc = cur_pc;
    while (!done) begin
      @(negedge i_clk);
      if (o_ready) begin
        exp_q.push_back(ref_step(cur_pc, ins));
        sent++;
        done = 1'b1;
      end
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout waiting for o_ready");
    end
    i_valid = 1'b0;
    cur_pc = cur_pc + 32'd4;
  endtask

  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout waiting for retire");
    end
    tests++;
    $display("test %s: %0d instructions, %0d errors, %s", name, sent - sent_mark,
             errors - err_mark, (errors == err_mark) ? "ok" : "FAIL");
    err_mark = errors;
    sent_mark = sent;
  endtask

  task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] want);
    errors++;
    $display("MISMATCH at %0t: %s is %h, expected %h (pc %h)", $time, what, got, want, head.pc);
  endtask

  // sampled at negedge, transfer happens on the next rising edge.
  always @(negedge i_clk) begin
    if (!i_rst && o_wb_valid && i_wb_ready) begin
      retired++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("instruction retired at %0t with none outstanding", $time);
      end else begin
        head = exp_q.pop_front();
        if (o_wb_pc !== head.pc) mismatch("pc", o_wb_pc, head.pc);
        if (o_wb_rdwen !== head.rdwen) mismatch("rdwen", {31'd0, o_wb_rdwen}, {31'd0, head.rdwen});
        if (o_wb_trap !== head.trap) mismatch("trap", {31'd0, o_wb_trap}, {31'd0, head.trap});
        if (head.rdwen && o_wb_rdid !== head.rdid)
          mismatch("rdid", {27'd0, o_wb_rdid}, {27'd0, head.rdid});
        if (head.rdwen && o_wb_data !== head.data) mismatch("data", o_wb_data, head.data);
        if (head.trap && o_wb_trap_pc !== head.trap_pc)
          mismatch("trap_pc", o_wb_trap_pc, head.trap_pc);
      end
    end
  end

  initial begin
    i_clk = 1'b0;
    i_rst = 1'b1;
    i_valid = 1'b0;
    i_pc = 32'd0;
    i_ins = 32'd0;
    i_wb_ready = 1'b0;
    cur_pc = 32'h0000_1000;
    ref_regs = '{default: 32'd0};
    ref_mscratch = 32'd0;
    ref_mtvec = MTVEC_INIT;
    ref_mepc = 32'd0;
    ref_mcause = 32'd0;
    repeat (3) next_cycle();
    i_rst = 1'b0;

    for (int k = 0; k < 200; k++) send_ins(gen_alu());
    finish_test("alu");
    for (int k = 0; k < 40; k++) send_ins(gen_upper());
    finish_test("lui_auipc");

    send_ins(csr_ins(rv_pkg::CSR_MSCRATCH, 5'd1, 3'b001, 5'd2));  // csrrw then read back.
    send_ins(csr_ins(rv_pkg::CSR_MSCRATCH, 5'd0, 3'b010, 5'd3));
    send_ins(csr_ins(12'h300, 5'd9, 3'b101, 5'd4));
    send_ins(csr_ins(12'h300, 5'd0, 3'b010, 5'd5));
    for (int k = 0; k < 80; k++) send_ins(gen_csr());
    finish_test("csr");

    send_ins(INS_ECALL);
    send_ins(csr_ins(rv_pkg::CSR_MEPC, 5'd0, 3'b010, 5'd1));
    send_ins(csr_ins(rv_pkg::CSR_MCAUSE, 5'd0, 3'b010, 5'd2));
    send_ins(INS_MRET);
    send_ins(csr_ins(rv_pkg::CSR_MEPC, 5'd20, 3'b101, 5'd0));
    send_ins(INS_MRET);
    for (int k = 0; k < 6; k++) begin
      send_ins(INS_ECALL);
      send_ins(INS_MRET);
    end
    finish_test("trap");

    for (int k = 0; k < 30; k++) send_ins(gen_unknown());
    send_ins({12'h123, 5'd1, 3'b000, 5'd0, rv_pkg::OP_IMM});
    send_ins({7'b0, 5'd2, 5'd1, 3'b000, 5'd0, rv_pkg::OP_OP});
    for (int k = 0; k < 8; k++) send_ins(read_reg(5'(k)));
    finish_test("unknown_x0");

    for (int k = 0; k < 300; k++) send_ins(gen_mixed());
    finish_test("mixed_bp");

    if (retired != sent) begin
      errors++;
      $display("%0d instructions accepted but %0d retired", sent, retired);
    end
    $display("summary: %0d tests, %0d retired, %0d errors", tests, retired, errors);
    if (errors == 0) $display("TESTS PASSED");
    else $display("TESTS FAILED");
    $finish;
  end

endmodule

/* rv_core.f */
rv_pkg.sv
dec_if.sv
res_if.sv
idu_normal.sv
idu_system.sv
idu.sv
exu.sv
wbu.sv
rv_core.sv
tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
